/* src/rrConfigPkg.sv */
// Register-read configuration
// Core sizes shared by the register file, the forwarding logic and the ready table

`default_nettype none

package rrConfigPkg;

  // Physical register tags
  localparam int TAG_W = 6;
  localparam int PHYS_REGS = 1 << TAG_W;       // 64 physical registers

  // Registers 0 .. ARCH_REGS-1 hold the committed state after reset
  localparam int ARCH_REGS = 32;

  // Defaults picked up by the top level
  localparam int LANES_DEFAULT = 2;
  localparam int DATA_W_DEFAULT = 32;

  typedef logic [TAG_W-1:0] tag_t;

endpackage

`default_nettype wire

/* src/rrPacketPkg.sv */
// Issue packet definition
// Fields carried from the issue queue through register read to execute

`default_nettype none

package rrPacketPkg;

  localparam int OPCODE_W = 8;
  localparam int IMM_W = 16;

  // 42 bits with 6-bit tags
  typedef struct packed {
    rrConfigPkg::tag_t     srcTag1;
    rrConfigPkg::tag_t     srcTag2;
    rrConfigPkg::tag_t     destTag;
    logic [OPCODE_W-1:0]   opcode;
    logic [IMM_W-1:0]      imm;
  } issuePkt_t;

endpackage

`default_nettype wire

/* src/physRegFile.sv */
// Physical register file
// Two combinational reads and one write per lane, writes held off during recovery

`default_nettype none

module physRegFile #(
  parameter int NUM_LANES = rrConfigPkg::LANES_DEFAULT,
  parameter int DATA_W    = rrConfigPkg::DATA_W_DEFAULT
) (
  input  wire logic                  clk,
  input  wire logic                  recover_i,
  input  rrPacketPkg::issuePkt_t     fuPacket_i [NUM_LANES],
  input  wire logic                  wbValid_i  [NUM_LANES],
  input  rrConfigPkg::tag_t          wbTag_i    [NUM_LANES],
  input  wire logic [DATA_W-1:0]     wbData_i   [NUM_LANES],
  output logic      [DATA_W-1:0]     rfData1_o  [NUM_LANES],
  output logic      [DATA_W-1:0]     rfData2_o  [NUM_LANES]
);

  import rrConfigPkg::*;

  logic [DATA_W-1:0] regArray [PHYS_REGS];

  always_ff @(posedge clk)
  begin
    for (int w = 0; w < NUM_LANES; w++)
    begin
      if (wbValid_i[w] && !recover_i)                    // Squashed results stay out of the array
      begin
        regArray[wbTag_i[w]] <= wbData_i[w];
      end
    end
  end

  always_comb
  begin
    for (int l = 0; l < NUM_LANES; l++)
    begin
      rfData1_o[l] = regArray[fuPacket_i[l].srcTag1];
      rfData2_o[l] = regArray[fuPacket_i[l].srcTag2];
    end
  end

  // Rename never hands out one tag to two producers in the same cycle
  for (genvar i = 0; i < NUM_LANES; i++)
  begin : genWbPairA
    for (genvar j = i + 1; j < NUM_LANES; j++)
    begin : genWbPairB
      assert property (@(posedge clk)
        (wbValid_i[i] && wbValid_i[j]) |-> (wbTag_i[i] != wbTag_i[j]))
        else $error("two writebacks to tag %0d in one cycle", wbTag_i[i]);
    end
  end

endmodule

`default_nettype wire

/* src/bypassNetwork.sv */
// Operand forwarding
// Picks a same-cycle writeback over the register file value for each source

`default_nettype none

module bypassNetwork #(
  parameter int NUM_LANES = rrConfigPkg::LANES_DEFAULT,
  parameter int DATA_W    = rrConfigPkg::DATA_W_DEFAULT
) (
  input  rrPacketPkg::issuePkt_t     fuPacket_i [NUM_LANES],
  input  wire logic                  wbValid_i  [NUM_LANES],
  input  rrConfigPkg::tag_t          wbTag_i    [NUM_LANES],
  input  wire logic [DATA_W-1:0]     wbData_i   [NUM_LANES],
  input  wire logic [DATA_W-1:0]     rfData1_i  [NUM_LANES],
  input  wire logic [DATA_W-1:0]     rfData2_i  [NUM_LANES],
  output logic      [DATA_W-1:0]     opData1_o  [NUM_LANES],
  output logic      [DATA_W-1:0]     opData2_o  [NUM_LANES]
);

  import rrConfigPkg::*;

  // One bit per writeback port that carries this tag
  function automatic logic [NUM_LANES-1:0] matchVec(tag_t srcTag);
    logic [NUM_LANES-1:0] hit;
    hit = '0;
    for (int w = 0; w < NUM_LANES; w++)
    begin
      hit[w] = wbValid_i[w] && (wbTag_i[w] == srcTag);
    end
    return hit;
  endfunction

  for (genvar l = 0; l < NUM_LANES; l++)
  begin : genLane
    logic [NUM_LANES-1:0] hit1;
    logic [NUM_LANES-1:0] hit2;

    always_comb
    begin
      hit1 = matchVec(fuPacket_i[l].srcTag1);
      hit2 = matchVec(fuPacket_i[l].srcTag2);
      opData1_o[l] = rfData1_i[l];                       // Array value unless forwarded
      opData2_o[l] = rfData2_i[l];
      for (int w = 0; w < NUM_LANES; w++)
      begin
        if (hit1[w])
        begin
          opData1_o[l] = wbData_i[w];
        end
        if (hit2[w])
        begin
          opData2_o[l] = wbData_i[w];
        end
      end
    end

    // A second hit would mean two producers for one register
    always_comb
    begin
      if (!$isunknown({hit1, hit2}))
      begin
        assert ($onehot0(hit1) && $onehot0(hit2))
          else $error("lane %0d source matches several writebacks", l);
      end
    end
  end

endmodule

`default_nettype wire

/* src/laneOutputReg.sv */
// Execute-side pipeline register
// Captures packet, valid and both operands of every lane each cycle

`default_nettype none

module laneOutputReg #(
  parameter int NUM_LANES = rrConfigPkg::LANES_DEFAULT,
  parameter int DATA_W    = rrConfigPkg::DATA_W_DEFAULT
) (
  input  wire logic                  clk,
  input  wire logic                  rstN_i,
  input  wire logic                  fuValid_i  [NUM_LANES],
  input  rrPacketPkg::issuePkt_t     fuPacket_i [NUM_LANES],
  input  wire logic [DATA_W-1:0]     opData1_i  [NUM_LANES],
  input  wire logic [DATA_W-1:0]     opData2_i  [NUM_LANES],
  output logic                       fuValid_o  [NUM_LANES],
  output rrPacketPkg::issuePkt_t     fuPacket_o [NUM_LANES],
  output logic      [DATA_W-1:0]     srcData1_o [NUM_LANES],
  output logic      [DATA_W-1:0]     srcData2_o [NUM_LANES]
);

  always_ff @(posedge clk or negedge rstN_i)
  begin
    if (!rstN_i)
    begin
      for (int l = 0; l < NUM_LANES; l++)
      begin
        fuValid_o[l] <= 1'b0;
      end
    end
    else
    begin
      for (int l = 0; l < NUM_LANES; l++)
      begin
        fuValid_o[l] <= fuValid_i[l];
      end
    end
  end

  // Packet and operands toward execute
  always_ff @(posedge clk)
  begin
    for (int l = 0; l < NUM_LANES; l++)
    begin
      fuPacket_o[l] <= fuPacket_i[l];
      srcData1_o[l] <= opData1_i[l];
      srcData2_o[l] <= opData2_i[l];
    end
  end

endmodule

`default_nettype wire

/* src/readyTable.sv */
// Physical register ready table
// Unmap clears a bit, wakeup and writeback set it
// Reset and exceptions return to the architectural registers only

`default_nettype none

module readyTable #(
  parameter int NUM_LANES = rrConfigPkg::LANES_DEFAULT
) (
  input  wire logic                           clk,
  input  wire logic                           rstN_i,
  input  wire logic                           exception_i,
  input  wire logic                           unmapValid_i [NUM_LANES],
  input  rrConfigPkg::tag_t                   unmapTag_i   [NUM_LANES],
  input  wire logic                           wakeValid_i  [NUM_LANES],
  input  rrConfigPkg::tag_t                   wakeTag_i    [NUM_LANES],
  input  wire logic                           wbValid_i    [NUM_LANES],
  input  rrConfigPkg::tag_t                   wbTag_i      [NUM_LANES],
  output logic [rrConfigPkg::PHYS_REGS-1:0]   phyRegRdy_o
);

  import rrConfigPkg::*;

  localparam logic [PHYS_REGS-1:0] RESET_RDY =
    {{(PHYS_REGS - ARCH_REGS){1'b0}}, {ARCH_REGS{1'b1}}};

  logic [PHYS_REGS-1:0] rdyNext;

  always_comb
  begin
    rdyNext = phyRegRdy_o;
    for (int l = 0; l < NUM_LANES; l++)
    begin
      if (unmapValid_i[l])
      begin
        rdyNext[unmapTag_i[l]] = 1'b0;
      end
    end
    // Sets come last so they win over a clear of the same tag
    for (int l = 0; l < NUM_LANES; l++)
    begin
      if (wakeValid_i[l])
      begin
        rdyNext[wakeTag_i[l]] = 1'b1;
      end
      if (wbValid_i[l])                                  // Counts even while recovering
      begin
        rdyNext[wbTag_i[l]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rstN_i)
  begin
    if (!rstN_i)
    begin
      phyRegRdy_o <= RESET_RDY;
    end
    else if (exception_i)
    begin
      phyRegRdy_o <= RESET_RDY;
    end
    else
    begin
      phyRegRdy_o <= rdyNext;
    end
  end

  // Issue logic reads these bits directly, so an unknown must never escape
  assert property (@(posedge clk) disable iff (!rstN_i) !$isunknown(phyRegRdy_o))
    else $error("ready table holds unknown bits");

endmodule

`default_nettype wire

/* src/regRead.sv */
// Register-read stage
// Reads both sources of every issued lane, forwards same-cycle writebacks
// and registers the result toward execute, with the ready table alongside

`default_nettype none

module regRead #(
  parameter int NUM_LANES = rrConfigPkg::LANES_DEFAULT,
  parameter int DATA_W    = rrConfigPkg::DATA_W_DEFAULT
) (
  input  wire logic                           clk,
  input  wire logic                           rstN_i,
  input  wire logic                           recover_i,
  input  wire logic                           exception_i,
  input  wire logic                           fuValid_i    [NUM_LANES],
  input  rrPacketPkg::issuePkt_t              fuPacket_i   [NUM_LANES],
  input  wire logic                           wbValid_i    [NUM_LANES],
  input  rrConfigPkg::tag_t                   wbTag_i      [NUM_LANES],
  input  wire logic [DATA_W-1:0]              wbData_i     [NUM_LANES],
  input  wire logic                           unmapValid_i [NUM_LANES],
  input  rrConfigPkg::tag_t                   unmapTag_i   [NUM_LANES],
  input  wire logic                           wakeValid_i  [NUM_LANES],
  input  rrConfigPkg::tag_t                   wakeTag_i    [NUM_LANES],
  output logic                                fuValid_o    [NUM_LANES],
  output rrPacketPkg::issuePkt_t              fuPacket_o   [NUM_LANES],
  output logic [DATA_W-1:0]                   srcData1_o   [NUM_LANES],
  output logic [DATA_W-1:0]                   srcData2_o   [NUM_LANES],
  output logic [rrConfigPkg::PHYS_REGS-1:0]   phyRegRdy_o
);

  logic [DATA_W-1:0] rfData1 [NUM_LANES];                // Array read data
  logic [DATA_W-1:0] rfData2 [NUM_LANES];
  logic [DATA_W-1:0] opData1 [NUM_LANES];                // After forwarding
  logic [DATA_W-1:0] opData2 [NUM_LANES];

  physRegFile #(
    .NUM_LANES (NUM_LANES),
    .DATA_W    (DATA_W)
  ) uPhysRegFile (
    .clk        (clk),
    .recover_i  (recover_i),
    .fuPacket_i (fuPacket_i),
    .wbValid_i  (wbValid_i),
    .wbTag_i    (wbTag_i),
    .wbData_i   (wbData_i),
    .rfData1_o  (rfData1),
    .rfData2_o  (rfData2)
  );

  bypassNetwork #(
    .NUM_LANES (NUM_LANES),
    .DATA_W    (DATA_W)
  ) uBypassNetwork (
    .fuPacket_i (fuPacket_i),
    .wbValid_i  (wbValid_i),
    .wbTag_i    (wbTag_i),
    .wbData_i   (wbData_i),
    .rfData1_i  (rfData1),
    .rfData2_i  (rfData2),
    .opData1_o  (opData1),
    .opData2_o  (opData2)
  );

  laneOutputReg #(
    .NUM_LANES (NUM_LANES),
    .DATA_W    (DATA_W)
  ) uLaneOutputReg (
    .clk        (clk),
    .rstN_i     (rstN_i),
    .fuValid_i  (fuValid_i),
    .fuPacket_i (fuPacket_i),
    .opData1_i  (opData1),
    .opData2_i  (opData2),
    .fuValid_o  (fuValid_o),
    .fuPacket_o (fuPacket_o),
    .srcData1_o (srcData1_o),
    .srcData2_o (srcData2_o)
  );

  readyTable #(
    .NUM_LANES (NUM_LANES)
  ) uReadyTable (
    .clk          (clk),
    .rstN_i       (rstN_i),
    .exception_i  (exception_i),
    .unmapValid_i (unmapValid_i),
    .unmapTag_i   (unmapTag_i),
    .wakeValid_i  (wakeValid_i),
    .wakeTag_i    (wakeTag_i),
    .wbValid_i    (wbValid_i),
    .wbTag_i      (wbTag_i),
    .phyRegRdy_o  (phyRegRdy_o)
  );

endmodule

`default_nettype wire

/* bench/regReadModel.svh */
// Register-read reference model
// Shadow register array and ready bits, and the prediction of the lane
// outputs and ready bits that follow the next rising edge

`ifndef REG_READ_MODEL_SVH
`define REG_READ_MODEL_SVH

logic [DATA_W-1:0]    shadowRegs    [PHYS_REGS];
bit                   shadowWritten [PHYS_REGS];
logic [PHYS_REGS-1:0] shadowRdy;                         // Expected phyRegRdy_o now

bit                   expValid  [LANES];
issuePkt_t            expPacket [LANES];
logic [DATA_W-1:0]    expData1  [LANES];
logic [DATA_W-1:0]    expData2  [LANES];
bit                   expKnown1 [LANES];                 // Source holds a defined value
bit                   expKnown2 [LANES];

// Architectural registers only
function automatic logic [PHYS_REGS-1:0] archReadyPattern();
  logic [PHYS_REGS-1:0] pattern;
  pattern = '0;
  for (int r = 0; r < ARCH_REGS; r++)
    pattern[r] = 1'b1;
  return pattern;
endfunction

// A same-cycle writeback beats the array, recover or not
function automatic logic [DATA_W-1:0] operandFor(tag_t tag, output bit known);
  logic [DATA_W-1:0] value;
  value = shadowRegs[tag];
  known = shadowWritten[tag];
  for (int w = 0; w < LANES; w++)
  begin
    if (wbValid_i[w] && wbTag_i[w] == tag)
    begin
      value = wbData_i[w];
      known = 1'b1;
    end
  end
  return value;
endfunction

// Uses the inputs that the next rising edge samples
function automatic void predictCycle();
  logic [PHYS_REGS-1:0] nextRdy;
  nextRdy = shadowRdy;
  for (int l = 0; l < LANES; l++)
  begin
    expValid[l] = rstN_i && fuValid_i[l];
    expPacket[l] = fuPacket_i[l];
    expData1[l] = operandFor(fuPacket_i[l].srcTag1, expKnown1[l]);
    expData2[l] = operandFor(fuPacket_i[l].srcTag2, expKnown2[l]);
    if (unmapValid_i[l])
      nextRdy[unmapTag_i[l]] = 1'b0;
  end
  for (int w = 0; w < LANES; w++)
  begin
    if (wbValid_i[w] && !recover_i)
    begin
      shadowRegs[wbTag_i[w]] = wbData_i[w];
      shadowWritten[wbTag_i[w]] = 1'b1;
    end
    if (wakeValid_i[w])                                  // Sets after all clears
      nextRdy[wakeTag_i[w]] = 1'b1;
    if (wbValid_i[w])
      nextRdy[wbTag_i[w]] = 1'b1;
  end
  if (!rstN_i || exception_i)
    nextRdy = archReadyPattern();
  shadowRdy = nextRdy;
endfunction

`endif

/* bench/regReadTb.sv */
// Testbench for the register-read stage
// Directed readback, forwarding, recovery and ready-table tests, then random traffic

`default_nettype none

module regReadTb;

  import rrConfigPkg::*;
  import rrPacketPkg::*;

  localparam int LANES = LANES_DEFAULT;
  localparam int DATA_W = DATA_W_DEFAULT;
  localparam int LAST = LANES - 1;
  localparam int CW = 128;                               // Width seen by the check task
  localparam int SEED = 84817;

  localparam int RESET_CYCLES = 3;
  localparam int WRITE_CYCLES = (PHYS_REGS + LANES - 1) / LANES;
  localparam int FORWARD_CYCLES = 8;
  localparam int RECOVER_PAIRS = 4;
  localparam int READY_CYCLES = 8;
  localparam int RANDOM_CYCLES = 300;
  localparam int DRAIN_CYCLES = 4;
  localparam int STIM_CYCLES = RESET_CYCLES + 2 * WRITE_CYCLES + FORWARD_CYCLES
    + 2 * RECOVER_PAIRS + READY_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 50;

  logic                 clk = 1'b0;
  logic                 rstN_i;
  logic                 recover_i;
  logic                 exception_i;
  logic                 fuValid_i    [LANES];
  issuePkt_t            fuPacket_i   [LANES];
  logic                 wbValid_i    [LANES];
  tag_t                 wbTag_i      [LANES];
  logic [DATA_W-1:0]    wbData_i     [LANES];
  logic                 unmapValid_i [LANES];
  tag_t                 unmapTag_i   [LANES];
  logic                 wakeValid_i  [LANES];
  tag_t                 wakeTag_i    [LANES];
  logic                 fuValid_o    [LANES];
  issuePkt_t            fuPacket_o   [LANES];
  logic [DATA_W-1:0]    srcData1_o   [LANES];
  logic [DATA_W-1:0]    srcData2_o   [LANES];
  logic [PHYS_REGS-1:0] phyRegRdy_o;

  int checkCount;
  int errorCount;
  int cycleCount;

  `include "regReadModel.svh"

  regRead #(
    .NUM_LANES (LANES),
    .DATA_W    (DATA_W)
  ) dut (.*);

  initial
  begin
    forever #10 clk = ~clk;
  end

  task automatic checkValue(input string what, input logic [CW-1:0] got,
                            input logic [CW-1:0] expected);
    checkCount++;
    if (got !== expected)
    begin
      errorCount++;
      $display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, expected);
    end
  endtask

  // Strobes last one cycle unless a test sets them again
  task automatic nextCycle();
    @(posedge clk);
    #2;
    recover_i = 1'b0;
    exception_i = 1'b0;
    for (int l = 0; l < LANES; l++)
    begin
      fuValid_i[l] = 1'b0;
      wbValid_i[l] = 1'b0;
      unmapValid_i[l] = 1'b0;
      wakeValid_i[l] = 1'b0;
    end
  endtask

  function automatic issuePkt_t makePacket(tag_t src1, tag_t src2);
    issuePkt_t pkt;
    pkt.srcTag1 = src1;
    pkt.srcTag2 = src2;
    pkt.destTag = tag_t'($urandom);
    pkt.opcode = OPCODE_W'($urandom);
    pkt.imm = IMM_W'($urandom);
    return pkt;
  endfunction

  function automatic tag_t pickWrittenTag();
    tag_t t;
    t = tag_t'($urandom);
    for (int i = 0; i < PHYS_REGS && !shadowWritten[t]; i++)
      t = tag_t'(t + 1);                                 // Walk to the next written tag
    return t;
  endfunction

  task automatic writeAllRegs();
    int t;
    for (int c = 0; c < WRITE_CYCLES; c++)
    begin
      nextCycle();
      for (int w = 0; w < LANES; w++)
      begin
        t = c * LANES + w;
        wbValid_i[w] = t < PHYS_REGS;
        wbTag_i[w] = tag_t'(t);
        wbData_i[w] = DATA_W'($urandom);
      end
    end
  endtask

  // Every tag shows up once as src1, in reverse order as src2
  task automatic readBackAll();
    int t;
    for (int c = 0; c < WRITE_CYCLES; c++)
    begin
      nextCycle();
      for (int l = 0; l < LANES; l++)
      begin
        t = (c * LANES + l) % PHYS_REGS;
        fuValid_i[l] = 1'b1;
        fuPacket_i[l] = makePacket(tag_t'(t), tag_t'(PHYS_REGS - 1 - t));
      end
    end
  endtask

  task automatic forwardTest();
    for (int c = 0; c < FORWARD_CYCLES; c++)
    begin
      nextCycle();
      for (int w = 0; w < LANES; w++)
      begin
        wbValid_i[w] = 1'b1;
        wbTag_i[w] = tag_t'((c * LANES + w + 7) % PHYS_REGS);
        wbData_i[w] = DATA_W'($urandom);
      end
      for (int l = 0; l < LANES; l++)
      begin
        fuValid_i[l] = 1'b1;
        fuPacket_i[l] = makePacket(wbTag_i[(l + 1) % LANES], wbTag_i[l]);
      end
    end
  endtask

  // Forwarded while recovering, then read again from the untouched array
  task automatic recoverTest();
    for (int p = 0; p < RECOVER_PAIRS; p++)
    begin
      nextCycle();
      recover_i = 1'b1;
      for (int w = 0; w < LANES; w++)
      begin
        wbValid_i[w] = 1'b1;
        wbTag_i[w] = tag_t'((40 + p * LANES + w) % PHYS_REGS);
        wbData_i[w] = DATA_W'($urandom);
      end
      for (int l = 0; l < LANES; l++)
      begin
        fuValid_i[l] = 1'b1;
        fuPacket_i[l] = makePacket(wbTag_i[l], wbTag_i[(l + 1) % LANES]);
      end
      nextCycle();
      for (int l = 0; l < LANES; l++)
      begin
        fuValid_i[l] = 1'b1;
        fuPacket_i[l] = makePacket(wbTag_i[l], wbTag_i[(l + 1) % LANES]);
      end
    end
  endtask

  task automatic readyTest();
    nextCycle();
    unmapValid_i[0] = 1'b1;
    unmapTag_i[0] = tag_t'(3);
    unmapValid_i[LAST] = 1'b1;
    unmapTag_i[LAST] = tag_t'(40);
    nextCycle();
    wakeValid_i[0] = 1'b1;
    wakeTag_i[0] = tag_t'(40);
    unmapValid_i[LAST] = 1'b1;
    unmapTag_i[LAST] = tag_t'(5);
    nextCycle();
    unmapValid_i[0] = 1'b1;                              // Clear and writeback on one tag
    unmapTag_i[0] = tag_t'(10);
    wbValid_i[0] = 1'b1;
    wbTag_i[0] = tag_t'(10);
    wbData_i[0] = DATA_W'($urandom);
    nextCycle();
    unmapValid_i[0] = 1'b1;
    unmapTag_i[0] = tag_t'(20);
    wakeValid_i[LAST] = 1'b1;
    wakeTag_i[LAST] = tag_t'(20);
    nextCycle();
    unmapValid_i[0] = 1'b1;
    unmapTag_i[0] = tag_t'(50);
    nextCycle();
    exception_i = 1'b1;
    unmapValid_i[0] = 1'b1;
    unmapTag_i[0] = tag_t'(0);
    wakeValid_i[LAST] = 1'b1;
    wakeTag_i[LAST] = tag_t'(60);
    nextCycle();
    checkValue("phyRegRdy_o after exception", CW'(phyRegRdy_o), CW'(archReadyPattern()));
    nextCycle();
  endtask

  task automatic randomTraffic();
    int base;
    for (int c = 0; c < RANDOM_CYCLES; c++)
    begin
      nextCycle();
      recover_i = ($urandom % 8) == 0;
      exception_i = ($urandom % 32) == 0;
      base = $urandom % PHYS_REGS;
      for (int l = 0; l < LANES; l++)
      begin
        wbValid_i[l] = ($urandom % 2) == 0;
        wbTag_i[l] = tag_t'((base + l) % PHYS_REGS);     // Distinct within the cycle
        wbData_i[l] = DATA_W'($urandom);
        unmapValid_i[l] = ($urandom % 4) == 0;
        unmapTag_i[l] = tag_t'($urandom);
        wakeValid_i[l] = ($urandom % 4) == 0;
        wakeTag_i[l] = tag_t'($urandom);
        fuValid_i[l] = ($urandom % 4) != 0;
        fuPacket_i[l] = makePacket(pickWrittenTag(), pickWrittenTag());
      end
    end
  endtask

  // Compare against the prediction made one cycle earlier
  always @(negedge clk)
  begin
    for (int l = 0; l < LANES; l++)
    begin
      checkValue($sformatf("fuValid_o[%0d]", l), CW'(fuValid_o[l]), CW'(expValid[l]));
      if (expValid[l])
      begin
        checkValue($sformatf("fuPacket_o[%0d]", l), CW'(fuPacket_o[l]), CW'(expPacket[l]));
        if (expKnown1[l])
          checkValue($sformatf("srcData1_o[%0d]", l), CW'(srcData1_o[l]), CW'(expData1[l]));
        if (expKnown2[l])
          checkValue($sformatf("srcData2_o[%0d]", l), CW'(srcData2_o[l]), CW'(expData2[l]));
      end
    end
    checkValue("phyRegRdy_o", CW'(phyRegRdy_o), CW'(shadowRdy));
    predictCycle();
  end

  initial
  begin
    cycleCount = 0;
    while (cycleCount < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("checks %0d errors %0d", checkCount, errorCount);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin
    void'($urandom(SEED));
    checkCount = 0;
    errorCount = 0;
    shadowRdy = archReadyPattern();
    rstN_i = 1'b0;
    recover_i = 1'b0;
    exception_i = 1'b0;
    for (int l = 0; l < LANES; l++)
    begin
      fuValid_i[l] = 1'b0;
      fuPacket_i[l] = '0;
      wbValid_i[l] = 1'b0;
      wbTag_i[l] = '0;
      wbData_i[l] = '0;
      unmapValid_i[l] = 1'b0;
      unmapTag_i[l] = '0;
      wakeValid_i[l] = 1'b0;
      wakeTag_i[l] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rstN_i = 1'b1;
    checkValue("phyRegRdy_o after reset", CW'(phyRegRdy_o), CW'(archReadyPattern()));
    writeAllRegs();
    readBackAll();
    forwardTest();
    recoverTest();
    readyTest();
    randomTraffic();
    repeat (DRAIN_CYCLES) nextCycle();
    @(negedge clk);
    #1;
    $display("checks %0d errors %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+bench
src/rrConfigPkg.sv
src/rrPacketPkg.sv
src/physRegFile.sv
src/bypassNetwork.sv
src/laneOutputReg.sv
src/readyTable.sv
src/regRead.sv
bench/regReadTb.sv

/* Makefile */
# Verilator build and run of the register-read testbench

VERILATOR ?= verilator
TOP       ?= regReadTb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
